// ==== build.f ====
synth_timing_pkg.sv
synth_voice_pkg.sv
timing_gen.sv
synth_clk_gen.sv
voice_osc_bank.sv
sample_mixer.sv
synth_top.sv
synth_properties.sv
synth_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module synth_tb -f build.f

./obj_dir/Vsynth_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== synth_tb.sv ====
`timescale 1ns/100ps

module synth_tb;

    localparam int VOICES   = synth_timing_pkg::VOICES_DEF;
    localparam int V_OSC    = synth_timing_pkg::V_OSC_DEF;
    localparam int OSC_DIV  = synth_timing_pkg::OSC_DIV_DEF;
    localparam int SLOTS    = VOICES * V_OSC;
    localparam int SLOT_W   = $clog2(SLOTS);
    localparam int PHASE_W  = synth_voice_pkg::PHASE_W_DEF;
    localparam int SAMPLE_W = synth_voice_pkg::SAMPLE_W_DEF;
    localparam int MIX_W    = SAMPLE_W + SLOT_W;
    localparam int TIMEOUT  = 200;  // cycles per wait

    logic                      AUDIO_CLK;
    logic                      reset_reg_N;
    logic                      trig;
    logic                      cfg_we;
    logic [SLOT_W-1:0]         cfg_slot;
    logic [PHASE_W-1:0]        cfg_freq;
    synth_voice_pkg::wave_op_t cfg_wave;
    logic                      run;
    logic [MIX_W-1:0]          sample_out;
    logic                      sample_valid;

    logic [31:0]               lfsr_state;
    int                        err_cnt;
    logic [PHASE_W-1:0]        m_phase [SLOTS];  // reference model state
    logic [PHASE_W-1:0]        m_freq  [SLOTS];
    synth_voice_pkg::wave_op_t m_wave  [SLOTS];

    synth_top #(
        .VOICES   (VOICES),
        .V_OSC    (V_OSC),
        .OSC_DIV  (OSC_DIV),
        .PHASE_W  (PHASE_W),
        .SAMPLE_W (SAMPLE_W)
    ) dut_i (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .trig         (trig),
        .cfg_we       (cfg_we),
        .cfg_slot     (cfg_slot),
        .cfg_freq     (cfg_freq),
        .cfg_wave     (cfg_wave),
        .run          (run),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

    initial
    begin
        AUDIO_CLK = 1'b0;
        forever #20 AUDIO_CLK = ~AUDIO_CLK;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return r;
    endfunction

    // expected slot sample from phase and waveform
    function automatic logic [SAMPLE_W-1:0] ref_sample(
        input logic [PHASE_W-1:0]        ph,
        input synth_voice_pkg::wave_op_t op
    );
        logic [PHASE_W-1:0] shifted;
        logic               msb;
        msb     = ph[PHASE_W-1];
        shifted = ph << 1;  // drop the msb for the triangle
        if (op == synth_voice_pkg::WAVE_SAW)
            return SAMPLE_W'(ph >> (PHASE_W - SAMPLE_W));
        if (op == synth_voice_pkg::WAVE_SQUARE)
            return msb ? {SAMPLE_W{1'b1}} : '0;
        if (op == synth_voice_pkg::WAVE_TRI)
            return SAMPLE_W'((msb ? ~shifted : shifted) >> (PHASE_W - SAMPLE_W));
        return '0;
    endfunction

    // advances every model phase once and returns the mixed sum
    task automatic predict_scan(output logic [MIX_W-1:0] exp);
        logic [MIX_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < SLOTS; i++)
        begin
            m_phase[i] = m_phase[i] + m_freq[i];
            sum        = sum + MIX_W'(ref_sample(m_phase[i], m_wave[i]));
        end
        exp = sum;
    endtask

    task automatic write_cfg(
        input int                        s,
        input logic [PHASE_W-1:0]        f,
        input synth_voice_pkg::wave_op_t w
    );
        @(negedge AUDIO_CLK);
        cfg_we   = 1'b1;
        cfg_slot = SLOT_W'(s);
        cfg_freq = f;
        cfg_wave = w;
        @(negedge AUDIO_CLK);
        cfg_we     = 1'b0;
        m_freq[s]  = f;
        m_wave[s]  = w;
        m_phase[s] = '0;  // write restarts the phase
    endtask

    task automatic pulse_trig();
        @(negedge AUDIO_CLK);
        trig = 1'b1;
        @(negedge AUDIO_CLK);
        trig = 1'b0;
    endtask

    task automatic wait_sample(output bit got);
        got = 1'b0;
        for (int n = 0; n < TIMEOUT && !got; n++)
        begin
            @(negedge AUDIO_CLK);
            got = sample_valid;
        end
        if (!got)
        begin
            $display("timeout while waiting for sample_valid");
            err_cnt++;
        end
    endtask

    task automatic scan_and_check(input string tag);
        logic [MIX_W-1:0] exp;
        bit               got;
        predict_scan(exp);
        pulse_trig();
        if (run !== 1'b1)
        begin
            $display("** Error: run = %h, expected %h (%s)", run, 1'b1, tag);
            err_cnt++;
        end
        wait_sample(got);
        if (got && run !== 1'b0)
        begin
            $display("** Error: run = %h, expected %h (%s)", run, 1'b0, tag);
            err_cnt++;
        end
        if (got && sample_out !== exp)
        begin
            $display("** Error: sample_out = %h, expected %h (%s)", sample_out, exp, tag);
            err_cnt++;
        end
    endtask

    task automatic check_reset_state();
        @(negedge AUDIO_CLK);
        if (run !== 1'b0 || sample_valid !== 1'b0 || sample_out !== '0)
        begin
            $display("** Error: run/sample_valid/sample_out = %h/%h/%h, expected 0/0/0",
                     run, sample_valid, sample_out);
            err_cnt++;
        end
        scan_and_check("unconfigured");
    endtask

    task automatic saw_sweep();
        for (int i = 0; i < SLOTS; i++)
            write_cfg(i, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_SAW);
        repeat (4) scan_and_check("saw");
    endtask

    task automatic opcode_mix();
        write_cfg(0, 16'h9000, synth_voice_pkg::WAVE_SQUARE);  // msb set after one step
        write_cfg(1, 16'hc123, synth_voice_pkg::WAVE_TRI);
        write_cfg(2, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_MUTE);
        write_cfg(3, 16'h3000, synth_voice_pkg::WAVE_SQUARE);
        write_cfg(4, 16'h5a5a, synth_voice_pkg::WAVE_TRI);
        write_cfg(5, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_SAW);
        write_cfg(6, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_TRI);
        write_cfg(7, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_SQUARE);
        repeat (3) scan_and_check("waveforms");
    endtask

    task automatic retrigger_ignored();
        int extra;
        extra = 0;
        fork
            scan_and_check("retrigger");
            begin
                repeat (8) @(negedge AUDIO_CLK);  // well inside the scan
                trig = 1'b1;
                @(negedge AUDIO_CLK);
                trig = 1'b0;
            end
        join
        repeat (40)
        begin
            @(negedge AUDIO_CLK);
            if (sample_valid || run)
                extra++;
        end
        if (extra != 0)
        begin
            $display("a second scan was started by the trig edge inside the running scan");
            err_cnt++;
        end
    endtask

    task automatic phase_clear();
        scan_and_check("before rewrite");
        write_cfg(5, PHASE_W'(rand_bits(PHASE_W)), synth_voice_pkg::WAVE_TRI);
        write_cfg(0, m_freq[0], m_wave[0]);  // same settings, phase back to zero
        repeat (2) scan_and_check("after rewrite");
    endtask

    initial
    begin
        reset_reg_N = 1'b0;
        trig        = 1'b0;
        cfg_we      = 1'b0;
        cfg_slot    = '0;
        cfg_freq    = '0;
        cfg_wave    = synth_voice_pkg::WAVE_SAW;
        err_cnt     = 0;
        lfsr_state  = 32'hc8de;
        for (int i = 0; i < SLOTS; i++)
        begin
            m_phase[i] = '0;
            m_freq[i]  = '0;
            m_wave[i]  = synth_voice_pkg::WAVE_SAW;
        end
        repeat (3) @(negedge AUDIO_CLK);
        reset_reg_N = 1'b1;

        check_reset_state();
        saw_sweep();
        opcode_mix();
        retrigger_ignored();
        phase_clear();

        $display("simulation finished with %0d errors", err_cnt);
        if (err_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== synth_properties.sv ====
`timescale 1ns/100ps

module synth_properties (
    input logic AUDIO_CLK,
    input logic reset_reg_N,
    input logic trig,
    input logic run,
    input logic sample_valid
);

    synth_timing_pkg::scan_state_t scan_st;

    assign scan_st = run ? synth_timing_pkg::SCAN_RUN : synth_timing_pkg::SCAN_IDLE;

    valid_one_cycle: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        sample_valid |=> !sample_valid)
        else $error("sample_valid wider than one cycle");

    idle_after_reset: assert property (@(posedge AUDIO_CLK)
        $rose(reset_reg_N) |-> !run)
        else $error("run high in the first cycle after reset");

    // run drops one cycle ahead of the mixed sample
    valid_after_run: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        sample_valid |-> ($past(run, 2) && !$past(run, 1)))
        else $error("sample_valid without a preceding fall of run");

    trig_starts_scan: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        ($rose(trig) && scan_st == synth_timing_pkg::SCAN_IDLE) |=> run)
        else $error("trig edge while idle did not raise run");

endmodule

bind synth_top synth_properties props_i (
    .AUDIO_CLK    (AUDIO_CLK),
    .reset_reg_N  (reset_reg_N),
    .trig         (trig),
    .run          (run),
    .sample_valid (sample_valid)
);

// ==== synth_top.sv ====
`timescale 1ns/100ps

module synth_top #(
    parameter int  VOICES   = synth_timing_pkg::VOICES_DEF,
    parameter int  V_OSC    = synth_timing_pkg::V_OSC_DEF,
    parameter int  OSC_DIV  = synth_timing_pkg::OSC_DIV_DEF,
    parameter int  PHASE_W  = synth_voice_pkg::PHASE_W_DEF,
    parameter int  SAMPLE_W = synth_voice_pkg::SAMPLE_W_DEF,
    localparam int SLOT_W   = $clog2(VOICES * V_OSC),
    localparam int MIX_W    = SAMPLE_W + $clog2(VOICES * V_OSC)
) (
    input  logic                      AUDIO_CLK,
    input  logic                      reset_reg_N,
    input  logic                      trig,
    input  logic                      cfg_we,
    input  logic [SLOT_W-1:0]         cfg_slot,
    input  logic [PHASE_W-1:0]        cfg_freq,
    input  synth_voice_pkg::wave_op_t cfg_wave,
    output logic                      run,
    output logic [MIX_W-1:0]          sample_out,
    output logic                      sample_valid
);

    logic                step;
    logic [SLOT_W-1:0]   slot;
    logic                slot_top;
    logic [SAMPLE_W-1:0] osc_sample;
    logic                osc_valid;
    logic                osc_last;

    synth_clk_gen #(
        .VOICES  (VOICES),
        .V_OSC   (V_OSC),
        .OSC_DIV (OSC_DIV)
    ) clk_gen_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .trig        (trig),
        .run         (run),
        .step        (step),
        .slot        (slot),
        .slot_top    (slot_top)
    );

    voice_osc_bank #(
        .VOICES   (VOICES),
        .V_OSC    (V_OSC),
        .PHASE_W  (PHASE_W),
        .SAMPLE_W (SAMPLE_W)
    ) osc_bank_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .step        (step),
        .slot        (slot),
        .slot_top    (slot_top),
        .cfg_we      (cfg_we),
        .cfg_slot    (cfg_slot),
        .cfg_freq    (cfg_freq),
        .cfg_wave    (cfg_wave),
        .osc_sample  (osc_sample),
        .osc_valid   (osc_valid),
        .osc_last    (osc_last)
    );

    sample_mixer #(
        .VOICES   (VOICES),
        .V_OSC    (V_OSC),
        .SAMPLE_W (SAMPLE_W)
    ) mixer_inst (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .osc_sample   (osc_sample),
        .osc_valid    (osc_valid),
        .osc_last     (osc_last),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

// ==== sample_mixer.sv ====
`timescale 1ns/100ps

module sample_mixer #(
    parameter int  VOICES   = synth_timing_pkg::VOICES_DEF,
    parameter int  V_OSC    = synth_timing_pkg::V_OSC_DEF,
    parameter int  SAMPLE_W = synth_voice_pkg::SAMPLE_W_DEF,
    localparam int MIX_W    = SAMPLE_W + $clog2(VOICES * V_OSC)
) (
    input  logic                AUDIO_CLK,
    input  logic                reset_reg_N,
    input  logic [SAMPLE_W-1:0] osc_sample,
    input  logic                osc_valid,
    input  logic                osc_last,
    output logic [MIX_W-1:0]    sample_out,
    output logic                sample_valid
);

    logic [MIX_W-1:0] acc;       // running sum of this scan
    logic [MIX_W-1:0] acc_next;

    assign acc_next = acc + MIX_W'(osc_sample);

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            acc          <= '0;
            sample_out   <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= osc_valid & osc_last;
            if (osc_valid && osc_last)
            begin
                sample_out <= acc_next;  // includes the top slot
                acc        <= '0;
            end
            else if (osc_valid)
            begin
                acc <= acc_next;
            end
        end
    end

endmodule

// ==== voice_osc_bank.sv ====
`timescale 1ns/100ps

module voice_osc_bank #(
    parameter int  VOICES   = synth_timing_pkg::VOICES_DEF,
    parameter int  V_OSC    = synth_timing_pkg::V_OSC_DEF,
    parameter int  PHASE_W  = synth_voice_pkg::PHASE_W_DEF,
    parameter int  SAMPLE_W = synth_voice_pkg::SAMPLE_W_DEF,
    localparam int SLOTS    = VOICES * V_OSC,
    localparam int SLOT_W   = $clog2(SLOTS)
) (
    input  logic                      AUDIO_CLK,
    input  logic                      reset_reg_N,
    input  logic                      step,
    input  logic [SLOT_W-1:0]         slot,
    input  logic                      slot_top,
    input  logic                      cfg_we,
    input  logic [SLOT_W-1:0]         cfg_slot,
    input  logic [PHASE_W-1:0]        cfg_freq,
    input  synth_voice_pkg::wave_op_t cfg_wave,
    output logic [SAMPLE_W-1:0]       osc_sample,
    output logic                      osc_valid,
    output logic                      osc_last
);

    logic [PHASE_W-1:0]        phase_mem [SLOTS];
    logic [PHASE_W-1:0]        freq_mem  [SLOTS];
    synth_voice_pkg::wave_op_t wave_mem  [SLOTS];
    logic [PHASE_W-1:0]        next_phase;

    function automatic logic [SAMPLE_W-1:0] shape(
        input logic [PHASE_W-1:0]        ph,
        input synth_voice_pkg::wave_op_t op
    );
        logic [SAMPLE_W-1:0] tri_raw;
        tri_raw = ph[PHASE_W-2 -: SAMPLE_W];  // skip the msb
        case (op)
            synth_voice_pkg::WAVE_SAW:    shape = ph[PHASE_W-1 -: SAMPLE_W];
            synth_voice_pkg::WAVE_SQUARE: shape = {SAMPLE_W{ph[PHASE_W-1]}};
            synth_voice_pkg::WAVE_TRI:    shape = ph[PHASE_W-1] ? ~tri_raw : tri_raw;
            default:                      shape = '0;  // mute
        endcase
    endfunction

    assign next_phase = phase_mem[slot] + freq_mem[slot];  // wraps mod 2^PHASE_W

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            for (int i = 0; i < SLOTS; i++)
            begin
                phase_mem[i] <= '0;
                freq_mem[i]  <= '0;
                wave_mem[i]  <= synth_voice_pkg::WAVE_SAW;
            end
        end
        else
        begin
            if (step)
                phase_mem[slot] <= next_phase;
            if (cfg_we)  // a write to the stepped slot wins
            begin
                phase_mem[cfg_slot] <= '0;
                freq_mem[cfg_slot]  <= cfg_freq;
                wave_mem[cfg_slot]  <= cfg_wave;
            end
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (step)
            osc_sample <= shape(next_phase, wave_mem[slot]);
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            osc_valid <= 1'b0;
            osc_last  <= 1'b0;
        end
        else
        begin
            osc_valid <= step;
            osc_last  <= step & slot_top;  // mixer closes the sum on this one
        end
    end

endmodule

// ==== synth_clk_gen.sv ====
`timescale 1ns/100ps

module synth_clk_gen #(
    parameter int  VOICES  = synth_timing_pkg::VOICES_DEF,
    parameter int  V_OSC   = synth_timing_pkg::V_OSC_DEF,
    parameter int  OSC_DIV = synth_timing_pkg::OSC_DIV_DEF,
    localparam int SLOT_W  = $clog2(VOICES * V_OSC)
) (
    input  logic              AUDIO_CLK,
    input  logic              reset_reg_N,
    input  logic              trig,
    output logic              run,
    output logic              step,      // one cycle per slot
    output logic [SLOT_W-1:0] slot,      // index counter
    output logic              slot_top
);

    localparam int DIV_W = (OSC_DIV > 1) ? $clog2(OSC_DIV) : 1;

    synth_timing_pkg::scan_state_t state;
    logic                          trig_dly;
    logic [DIV_W-1:0]              div_cnt;
    logic                          trig_rise;
    logic                          scan_end;
    logic                          div_wrap;

    assign trig_rise = trig & ~trig_dly;
    assign scan_end  = step & slot_top;  // last slot just stepped
    assign div_wrap  = (div_cnt == DIV_W'(OSC_DIV - 1));
    assign run       = (state == synth_timing_pkg::SCAN_RUN);

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            trig_dly <= 1'b0;
            state    <= synth_timing_pkg::SCAN_IDLE;
        end
        else
        begin
            trig_dly <= trig;
            if (scan_end)
                state <= synth_timing_pkg::SCAN_IDLE;
            else if (trig_rise && !run)  // retrigger ignored
                state <= synth_timing_pkg::SCAN_RUN;
        end
    end

    // the divider restarts with every scan, so the first step comes OSC_DIV cycles after run rises
    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N || !run || scan_end)
        begin
            div_cnt <= '0;
            step    <= 1'b0;
        end
        else
        begin
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            step    <= div_wrap;
        end
    end

    timing_gen #(
        .VOICES (VOICES),
        .V_OSC  (V_OSC)
    ) timing_gen_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .step        (step),
        .slot        (slot),
        .slot_top    (slot_top)
    );

endmodule

// ==== timing_gen.sv ====
`timescale 1ns/100ps

module timing_gen #(
    parameter int  VOICES = synth_timing_pkg::VOICES_DEF,
    parameter int  V_OSC  = synth_timing_pkg::V_OSC_DEF,
    localparam int SLOTS  = VOICES * V_OSC,
    localparam int SLOT_W = $clog2(SLOTS)
) (
    input  logic              AUDIO_CLK,
    input  logic              reset_reg_N,
    input  logic              step,
    output logic [SLOT_W-1:0] slot,
    output logic              slot_top
);

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(SLOTS - 1);

    // slot stays put between steps so the bank can read it on the step cycle
    assign slot_top = (slot == LAST_SLOT);

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            slot <= '0;
        end
        else if (step)
        begin
            if (slot_top)
                slot <= '0;  // scan done, back to first slot
            else
                slot <= slot + 1'b1;
        end
    end

endmodule

// ==== synth_voice_pkg.sv ====
package synth_voice_pkg;

    // waveform select for one oscillator slot
    typedef enum logic [1:0]
    {
        WAVE_SAW    = 2'd0,  // ramp, reset default
        WAVE_SQUARE = 2'd1,  // phase msb spread over the sample
        WAVE_TRI    = 2'd2,  // folded ramp
        WAVE_MUTE   = 2'd3   // silent slot
    } wave_op_t;

    // data widths
    // phase accumulator and frequency word share one width
    localparam int PHASE_W_DEF = 16;  // accumulator bits

    // per-slot sample before mixing
    localparam int SAMPLE_W_DEF = 8;  // sample bits

    // the triangle shaper takes bits below the phase msb,
    // so PHASE_W has to be larger than SAMPLE_W

endpackage

// ==== synth_timing_pkg.sv ====
package synth_timing_pkg;

    // scan controller states
    typedef enum logic
    {
        SCAN_IDLE = 1'b0,  // waiting for trig
        SCAN_RUN  = 1'b1   // stepping through the slots
    } scan_state_t;

    // voice layout
    // one scan visits VOICES * V_OSC oscillator slots
    localparam int VOICES_DEF = 4;  // polyphony
    localparam int V_OSC_DEF  = 2;  // oscs per voice

    // step divider
    // the step strobe fires once every OSC_DIV audio clock cycles while a scan runs
    localparam int OSC_DIV_DEF = 3;  // clocks per step

endpackage
